// File: Makefile
TOP := tb_dcache

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f all.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

// File: all.f
src/dcache_pkg.sv
src/dcache_ways.sv
src/dcache_ctrl.sv
src/dcache_top.sv
verif/wb_mem_model.sv
verif/tb_dcache.sv

// File: src/dcache_ctrl.sv
module dcache_ctrl #(
    parameter int NUM_SETS = 8
) (
    input  logic                                          CLK,
    input  logic                                          n_rst,
    input  logic                                          dmemREN,
    input  logic                                          dmemWEN,
    input  dcache_pkg::word_t                             dmemaddr,
    input  logic                                          halt,
    output logic                                          dhit,
    output logic                                          flushed,
    output logic [$clog2(NUM_SETS)-1:0]                   set_idx,
    output logic                                          way_sel,
    output dcache_pkg::ways_op_t                          op,
    output logic [$bits(dcache_pkg::word_t)-$clog2(NUM_SETS)
                  -dcache_pkg::BLK_OFF_W-dcache_pkg::BYTE_OFF_W-1:0] req_tag,
    output logic                                          blk_off,
    input  logic                                          hit,
    input  logic                                          hit_way,
    input  logic                                          lru_way,
    input  logic [1:0]                                    way_dirty,
    input  logic [$bits(dcache_pkg::word_t)-$clog2(NUM_SETS)
                  -dcache_pkg::BLK_OFF_W-dcache_pkg::BYTE_OFF_W-1:0] sel_tag,
    input  dcache_pkg::word_t                             sel_word0,
    input  dcache_pkg::word_t                             sel_word1,
    output logic                                          wb_cyc,
    output logic                                          wb_stb,
    output logic                                          wb_we,
    output dcache_pkg::word_t                             wb_adr,
    output dcache_pkg::word_t                             wb_dat_w,
    input  dcache_pkg::word_t                             wb_dat_r,
    input  logic                                          wb_ack
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(dcache_pkg::word_t) - IDX_W
                           - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W;
    localparam int IDX_LSB = dcache_pkg::BYTE_OFF_W + dcache_pkg::BLK_OFF_W;
    localparam logic [IDX_W-1:0] LAST_SET = IDX_W'(NUM_SETS - 1);

    typedef enum logic [3:0] {
        S_IDLE,
        S_WB0,
        S_WB1,
        S_FILL0,
        S_FILL1,
        S_FLUSH_SCAN,
        S_FLUSH_WB0,
        S_FLUSH_WB1,
        S_DONE
    } state_t;

    state_t            state, state_d;
    logic              way_q, way_d;
    logic [IDX_W-1:0]  flush_idx, flush_d;
    logic [IDX_W-1:0]  req_idx;
    logic              req;
    logic              flushing;
    logic              bus_done;
    logic              cyc_d, stb_d, we_d;
    dcache_pkg::word_t adr_d, dat_d;

    function automatic dcache_pkg::word_t blk_addr(
        input logic [TAG_W-1:0]                     tag,
        input logic [IDX_W-1:0]                     idx,
        input logic [dcache_pkg::BLK_OFF_W-1:0]     word_sel
    );
        return {tag, idx, word_sel, {dcache_pkg::BYTE_OFF_W{1'b0}}};
    endfunction

    // address fields of the processor request
    assign req_tag = dmemaddr[$bits(dcache_pkg::word_t)-1 -: TAG_W];
    assign req_idx = dmemaddr[IDX_LSB +: IDX_W];
    assign blk_off = dmemaddr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::BLK_OFF_W];

    assign req      = dmemREN || dmemWEN;
    assign bus_done = wb_cyc && wb_stb && wb_ack;
    assign flushing = (state == S_FLUSH_SCAN) || (state == S_FLUSH_WB0)
                      || (state == S_FLUSH_WB1) || (state == S_DONE);
    assign set_idx  = flushing ? flush_idx : req_idx;
    assign flushed  = (state == S_DONE);

    always_comb begin
        case (state)
            S_IDLE:       way_sel = hit ? hit_way : lru_way;
            // way 0 first when both are dirty
            S_FLUSH_SCAN: way_sel = ~way_dirty[0];
            default:      way_sel = way_q;
        endcase
    end

    always_comb begin
        state_d = state;
        way_d   = way_q;
        flush_d = flush_idx;
        cyc_d   = wb_cyc;
        stb_d   = wb_stb;
        we_d    = wb_we;
        adr_d   = wb_adr;
        dat_d   = wb_dat_w;
        op      = dcache_pkg::WOP_NONE;
        dhit    = 1'b0;
        case (state)
            S_IDLE: begin
                if (halt) begin
                    state_d = S_FLUSH_SCAN;
                    flush_d = '0;
                end else if (req && hit) begin
                    dhit = 1'b1;
                    if (dmemWEN) begin
                        op = dcache_pkg::WOP_HIT_WRITE;
                    end else begin
                        op = dcache_pkg::WOP_HIT_READ;
                    end
                end else if (req) begin
                    way_d = lru_way;
                    cyc_d = 1'b1;
                    stb_d = 1'b1;
                    if (way_dirty[lru_way]) begin
                        state_d = S_WB0;
                        we_d    = 1'b1;
                        adr_d   = blk_addr(sel_tag, req_idx, 1'b0);
                        dat_d   = sel_word0;
                    end else begin
                        state_d = S_FILL0;
                        we_d    = 1'b0;
                        adr_d   = blk_addr(req_tag, req_idx, 1'b0);
                    end
                end
            end
            S_WB0, S_FLUSH_WB0: begin
                if (bus_done) begin
                    state_d = (state == S_WB0) ? S_WB1 : S_FLUSH_WB1;
                    adr_d   = blk_addr(sel_tag, set_idx, 1'b1);
                    dat_d   = sel_word1;
                end
            end
            S_WB1: begin
                if (bus_done) begin
                    op      = dcache_pkg::WOP_CLEAN;
                    state_d = S_FILL0;
                    we_d    = 1'b0;
                    adr_d   = blk_addr(req_tag, req_idx, 1'b0);
                end
            end
            S_FILL0: begin
                if (bus_done) begin
                    op      = dcache_pkg::WOP_FILL0;
                    state_d = S_FILL1;
                    adr_d   = blk_addr(req_tag, req_idx, 1'b1);
                end
            end
            S_FILL1: begin
                // held request hits once back in idle
                if (bus_done) begin
                    op      = dcache_pkg::WOP_FILL1;
                    state_d = S_IDLE;
                    cyc_d   = 1'b0;
                    stb_d   = 1'b0;
                end
            end
            S_FLUSH_SCAN: begin
                if (|way_dirty) begin
                    way_d   = ~way_dirty[0];
                    state_d = S_FLUSH_WB0;
                    cyc_d   = 1'b1;
                    stb_d   = 1'b1;
                    we_d    = 1'b1;
                    adr_d   = blk_addr(sel_tag, flush_idx, 1'b0);
                    dat_d   = sel_word0;
                end else if (flush_idx == LAST_SET) begin
                    state_d = S_DONE;
                end else begin
                    flush_d = flush_idx + 1'b1;
                end
            end
            S_FLUSH_WB1: begin
                // rescan the same set for the other way
                if (bus_done) begin
                    op      = dcache_pkg::WOP_CLEAN;
                    state_d = S_FLUSH_SCAN;
                    cyc_d   = 1'b0;
                    stb_d   = 1'b0;
                    we_d    = 1'b0;
                end
            end
            default: begin
            end
        endcase
    end

    always_ff @(posedge CLK or negedge n_rst) begin
        if (!n_rst) begin
            state     <= S_IDLE;
            way_q     <= 1'b0;
            flush_idx <= '0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            wb_we     <= 1'b0;
        end else begin
            state     <= state_d;
            way_q     <= way_d;
            flush_idx <= flush_d;
            wb_cyc    <= cyc_d;
            wb_stb    <= stb_d;
            wb_we     <= we_d;
        end
    end

    always_ff @(posedge CLK) begin
        wb_adr   <= adr_d;
        wb_dat_w <= dat_d;
    end

    a_stb_in_cyc : assert property (@(posedge CLK) disable iff (!n_rst)
        wb_stb |-> wb_cyc);

    // wait states only stretch the current word
    a_hold_req : assert property (@(posedge CLK) disable iff (!n_rst)
        (wb_stb && !wb_ack) |=> ($stable(wb_adr) && $stable(wb_we)));

endmodule

// File: src/dcache_pkg.sv
package dcache_pkg;

    // processor word and byte address
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // byte offset inside a word
    localparam int BYTE_OFF_W = 2;

    // word select inside a two-word block
    localparam int BLK_OFF_W = 1;

    // array operation, applied by the way arrays at the next rising edge
    typedef enum logic [2:0] {
        // no array update
        WOP_NONE,
        // store word into the hitting way, mark dirty, move LRU
        WOP_HIT_WRITE,
        // first fill word and new tag, frame not valid yet
        WOP_FILL0,
        // second fill word, frame valid and clean
        WOP_FILL1,
        // block is back in memory
        WOP_CLEAN,
        // read hit, only the LRU bit moves
        WOP_HIT_READ
    } ways_op_t;

endpackage

// File: src/dcache_top.sv
module dcache_top #(
    parameter int NUM_SETS = 8
) (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              dmemREN,
    input  logic              dmemWEN,
    input  dcache_pkg::word_t dmemaddr,
    input  dcache_pkg::word_t dmemstore,
    input  logic              halt,
    output dcache_pkg::word_t dmemload,
    output logic              dhit,
    output logic              flushed,
    output logic              wb_cyc,
    output logic              wb_stb,
    output logic              wb_we,
    output dcache_pkg::word_t wb_adr,
    output dcache_pkg::word_t wb_dat_w,
    input  dcache_pkg::word_t wb_dat_r,
    input  logic              wb_ack
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(dcache_pkg::word_t) - IDX_W
                           - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W;

    logic [IDX_W-1:0]     set_idx;
    logic                 way_sel;
    dcache_pkg::ways_op_t op;
    logic [TAG_W-1:0]     req_tag;
    logic                 blk_off;
    logic                 hit;
    logic                 hit_way;
    logic                 lru_way;
    logic [1:0]           way_dirty;
    logic [TAG_W-1:0]     sel_tag;
    dcache_pkg::word_t    sel_word0;
    dcache_pkg::word_t    sel_word1;

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .halt      (halt),
        .dhit      (dhit),
        .flushed   (flushed),
        .set_idx   (set_idx),
        .way_sel   (way_sel),
        .op        (op),
        .req_tag   (req_tag),
        .blk_off   (blk_off),
        .hit       (hit),
        .hit_way   (hit_way),
        .lru_way   (lru_way),
        .way_dirty (way_dirty),
        .sel_tag   (sel_tag),
        .sel_word0 (sel_word0),
        .sel_word1 (sel_word1),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    // fill data comes straight off the bus
    dcache_ways #(
        .NUM_SETS (NUM_SETS)
    ) u_ways (
        .CLK        (CLK),
        .n_rst      (n_rst),
        .set_idx    (set_idx),
        .way_sel    (way_sel),
        .op         (op),
        .req_tag    (req_tag),
        .blk_off    (blk_off),
        .store_word (dmemstore),
        .fill_word  (wb_dat_r),
        .hit        (hit),
        .hit_way    (hit_way),
        .lru_way    (lru_way),
        .way_dirty  (way_dirty),
        .sel_tag    (sel_tag),
        .sel_word0  (sel_word0),
        .sel_word1  (sel_word1),
        .load_word  (dmemload)
    );

endmodule

// File: src/dcache_ways.sv
module dcache_ways #(
    parameter int NUM_SETS = 8
) (
    input  logic                                          CLK,
    input  logic                                          n_rst,
    input  logic [$clog2(NUM_SETS)-1:0]                   set_idx,
    input  logic                                          way_sel,
    input  dcache_pkg::ways_op_t                          op,
    input  logic [$bits(dcache_pkg::word_t)-$clog2(NUM_SETS)
                  -dcache_pkg::BLK_OFF_W-dcache_pkg::BYTE_OFF_W-1:0] req_tag,
    input  logic                                          blk_off,
    input  dcache_pkg::word_t                             store_word,
    input  dcache_pkg::word_t                             fill_word,
    output logic                                          hit,
    output logic                                          hit_way,
    output logic                                          lru_way,
    output logic [1:0]                                    way_dirty,
    output logic [$bits(dcache_pkg::word_t)-$clog2(NUM_SETS)
                  -dcache_pkg::BLK_OFF_W-dcache_pkg::BYTE_OFF_W-1:0] sel_tag,
    output dcache_pkg::word_t                             sel_word0,
    output dcache_pkg::word_t                             sel_word1,
    output dcache_pkg::word_t                             load_word
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = $bits(dcache_pkg::word_t) - IDX_W
                           - dcache_pkg::BLK_OFF_W - dcache_pkg::BYTE_OFF_W;

    // per-way state bits, way is the outer index
    logic [1:0][NUM_SETS-1:0] valid_bits;
    logic [1:0][NUM_SETS-1:0] dirty_bits;

    // one bit per set, names the victim way
    logic [NUM_SETS-1:0] lru_bits;

    logic [TAG_W-1:0]  tag_mem  [2][NUM_SETS];
    dcache_pkg::word_t data_mem [2][NUM_SETS][2];

    logic [1:0] way_match;

    for (genvar w = 0; w < 2; w++) begin : g_match
        assign way_match[w] = valid_bits[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
    end

    assign hit       = |way_match;
    assign hit_way   = way_match[1];
    assign lru_way   = lru_bits[set_idx];
    assign way_dirty = {dirty_bits[1][set_idx], dirty_bits[0][set_idx]};
    assign load_word = data_mem[hit_way][set_idx][blk_off];

    // victim or flush frame, for writeback
    assign sel_tag   = tag_mem[way_sel][set_idx];
    assign sel_word0 = data_mem[way_sel][set_idx][0];
    assign sel_word1 = data_mem[way_sel][set_idx][1];

    always_ff @(posedge CLK or negedge n_rst) begin
        if (!n_rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            lru_bits   <= '0;
        end else begin
            case (op)
                dcache_pkg::WOP_HIT_READ: begin
                    lru_bits[set_idx] <= ~way_sel;
                end
                dcache_pkg::WOP_HIT_WRITE: begin
                    dirty_bits[way_sel][set_idx] <= 1'b1;
                    lru_bits[set_idx]            <= ~way_sel;
                end
                dcache_pkg::WOP_FILL0: begin
                    // half-filled frame must not hit
                    valid_bits[way_sel][set_idx] <= 1'b0;
                end
                dcache_pkg::WOP_FILL1: begin
                    valid_bits[way_sel][set_idx] <= 1'b1;
                    dirty_bits[way_sel][set_idx] <= 1'b0;
                    lru_bits[set_idx]            <= ~way_sel;
                end
                dcache_pkg::WOP_CLEAN: begin
                    dirty_bits[way_sel][set_idx] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        case (op)
            dcache_pkg::WOP_HIT_WRITE: begin
                data_mem[way_sel][set_idx][blk_off] <= store_word;
            end
            dcache_pkg::WOP_FILL0: begin
                tag_mem[way_sel][set_idx]     <= req_tag;
                data_mem[way_sel][set_idx][0] <= fill_word;
            end
            dcache_pkg::WOP_FILL1: begin
                data_mem[way_sel][set_idx][1] <= fill_word;
            end
            default: begin
            end
        endcase
    end

    // a fill only goes to a way after a miss, so no set ever holds a tag twice
    for (genvar s = 0; s < NUM_SETS; s++) begin : g_tag_check
        a_unique_tag : assert property (@(posedge CLK) disable iff (!n_rst)
            !(valid_bits[0][s] && valid_bits[1][s] && (tag_mem[0][s] == tag_mem[1][s])));
    end

endmodule

// File: verif/tb_dcache.sv
module tb_dcache;

    localparam int NUM_SETS   = 8;
    localparam int MEM_AW     = 8;
    localparam int MEM_WORDS  = 1 << MEM_AW;
    localparam int HIT_WAIT   = 100;
    localparam int FLUSH_WAIT = 2000;
    localparam int RAND_OPS   = 300;

    logic              CLK;
    logic              n_rst;
    logic              dmemREN;
    logic              dmemWEN;
    dcache_pkg::word_t dmemaddr;
    dcache_pkg::word_t dmemstore;
    logic              halt;
    dcache_pkg::word_t dmemload;
    logic              dhit;
    logic              flushed;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    dcache_pkg::word_t wb_adr;
    dcache_pkg::word_t wb_dat_w;
    dcache_pkg::word_t wb_dat_r;
    logic              wb_ack;

    logic [31:0]       lfsr;
    // stores seen by the processor side, keyed by byte address
    dcache_pkg::word_t shadow [dcache_pkg::word_t];

    dcache_top #(
        .NUM_SETS (NUM_SETS)
    ) dut (
        .CLK       (CLK),
        .n_rst     (n_rst),
        .dmemREN   (dmemREN),
        .dmemWEN   (dmemWEN),
        .dmemaddr  (dmemaddr),
        .dmemstore (dmemstore),
        .halt      (halt),
        .dmemload  (dmemload),
        .dhit      (dhit),
        .flushed   (flushed),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack)
    );

    wb_mem_model #(
        .DEPTH (MEM_WORDS),
        .SEED  (32'h197d_a170)
    ) mem_model (
        .CLK      (CLK),
        .n_rst    (n_rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial CLK = 1'b0;
    always #5 CLK = ~CLK;

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1);
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic dcache_pkg::word_t init_word(input dcache_pkg::word_t addr);
        return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::word_t addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return init_word(addr);
    endfunction

    function automatic int mem_slot(input dcache_pkg::word_t addr);
        return int'(addr[2 +: MEM_AW]);
    endfunction

    // called at a falling edge, returns at the falling edge after dhit
    task automatic cpu_access(input logic write, input dcache_pkg::word_t addr,
                              input dcache_pkg::word_t data, output int cycles,
                              output logic used_bus);
        logic got_hit;
        dmemREN   = !write;
        dmemWEN   = write;
        dmemaddr  = addr;
        dmemstore = data;
        cycles    = 0;
        used_bus  = 1'b0;
        got_hit   = 1'b0;
        while (!got_hit) begin
            @(posedge CLK);
            cycles++;
            used_bus = used_bus || wb_cyc;
            got_hit  = dhit;
            if (!got_hit && cycles >= HIT_WAIT) begin
                stop_on_error($sformatf("timeout waiting for dhit on access to %h", addr));
            end
        end
        @(negedge CLK);
        dmemREN = 1'b0;
        dmemWEN = 1'b0;
    endtask

    task automatic expect_hit(input int cycles, input logic used_bus, input string what);
        assert (cycles == 1 && !used_bus)
        else stop_on_error($sformatf("%s missed or went to the bus", what));
    endtask

    // checks every finished read, records every finished store
    always @(posedge CLK) begin
        if (n_rst && dhit && dmemREN) begin
            assert (dmemload === expected_word(dmemaddr))
            else stop_on_error($sformatf("ERR %0t: read of %h returned %h, expected %h",
                                         $time, dmemaddr, dmemload, expected_word(dmemaddr)));
        end
        if (n_rst && dhit && dmemWEN) begin
            shadow[dmemaddr] = dmemstore;
        end
    end

    initial begin
        int                cycles;
        logic              used_bus;
        logic              write;
        logic [31:0]       rnd;
        dcache_pkg::word_t addr;
        dcache_pkg::word_t data;
        int                waited;

        lfsr          = 32'h197d_a170;
        n_rst         = 1'b0;
        dmemREN       = 1'b0;
        dmemWEN       = 1'b0;
        dmemaddr      = '0;
        dmemstore     = '0;
        halt          = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem_model.mem[i] = init_word(dcache_pkg::word_t'(i * 4));
        end
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        n_rst = 1'b1;
        @(negedge CLK);

        // read miss, then the other word of the same block
        cpu_access(1'b0, 32'h0000_020c, '0, cycles, used_bus);
        assert (used_bus) else stop_on_error("first read of block 0x208 never used the bus");
        cpu_access(1'b0, 32'h0000_0208, '0, cycles, used_bus);
        expect_hit(cycles, used_bus, "read of the other word of block 0x208");

        // write hit, read back
        cpu_access(1'b1, 32'h0000_020c, 32'hcafe_0001, cycles, used_bus);
        expect_hit(cycles, used_bus, "write to 0x20c");
        cpu_access(1'b0, 32'h0000_020c, '0, cycles, used_bus);
        expect_hit(cycles, used_bus, "read back of 0x20c");

        // dirty victim in set 2
        cpu_access(1'b1, 32'h0000_0210, 32'h1234_5678, cycles, used_bus);
        cpu_access(1'b0, 32'h0000_0250, '0, cycles, used_bus);
        cpu_access(1'b0, 32'h0000_0290, '0, cycles, used_bus);
        assert (mem_model.mem[mem_slot(32'h0000_0210)] === 32'h1234_5678)
        else stop_on_error($sformatf("ERR %0t: memory at 0x210 holds %h after eviction",
                                     $time, mem_model.mem[mem_slot(32'h0000_0210)]));
        cpu_access(1'b0, 32'h0000_0210, '0, cycles, used_bus);
        assert (used_bus) else stop_on_error("evicted block 0x210 still hit");

        // LRU order in set 3
        cpu_access(1'b0, 32'h0000_0218, '0, cycles, used_bus);
        cpu_access(1'b0, 32'h0000_0258, '0, cycles, used_bus);
        cpu_access(1'b0, 32'h0000_0218, '0, cycles, used_bus);
        expect_hit(cycles, used_bus, "re-read of block 0x218");
        cpu_access(1'b0, 32'h0000_0298, '0, cycles, used_bus);
        cpu_access(1'b0, 32'h0000_0218, '0, cycles, used_bus);
        expect_hit(cycles, used_bus, "read of recently used block 0x218");
        cpu_access(1'b0, 32'h0000_0258, '0, cycles, used_bus);
        assert (used_bus) else stop_on_error("least recently used block 0x258 was not evicted");

        // 64 words, four tags per set
        for (int n = 0; n < RAND_OPS; n++) begin
            rnd   = draw_bits(1);
            write = rnd[0];
            rnd   = draw_bits(6);
            addr  = {24'h0, rnd[5:0], 2'b00};
            data  = draw_bits(32);
            cpu_access(write, addr, data, cycles, used_bus);
        end

        halt   = 1'b1;
        waited = 0;
        while (!flushed) begin
            @(posedge CLK);
            waited++;
            if (!flushed && waited >= FLUSH_WAIT) begin
                stop_on_error("timeout waiting for flushed after halt");
            end
        end
        @(negedge CLK);
        halt = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr = dcache_pkg::word_t'(i * 4);
            assert (mem_model.mem[i] === expected_word(addr))
            else stop_on_error($sformatf("ERR %0t: memory at %h holds %h after flush, expected %h",
                                         $time, addr, mem_model.mem[i], expected_word(addr)));
        end
        repeat (10) begin
            @(posedge CLK);
            assert (flushed) else stop_on_error("flushed dropped after the flush had finished");
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: verif/wb_mem_model.sv
module wb_mem_model #(
    parameter int          DEPTH = 256,
    parameter logic [31:0] SEED  = 32'h197d_a170
) (
    input  logic              CLK,
    input  logic              n_rst,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  dcache_pkg::word_t wb_adr,
    input  dcache_pkg::word_t wb_dat_w,
    output dcache_pkg::word_t wb_dat_r,
    output logic              wb_ack
);

    localparam int AW = $clog2(DEPTH);

    // word storage, preloaded and inspected by the testbench
    dcache_pkg::word_t mem [DEPTH];

    logic [31:0] lfsr;
    logic        busy;
    logic [1:0]  wait_left;

    // right-shift Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    always @(posedge CLK or negedge n_rst) begin
        logic [31:0] s;
        logic [1:0]  delay;
        if (!n_rst) begin
            lfsr      <= SEED;
            busy      <= 1'b0;
            wait_left <= '0;
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                delay = wait_left;
                // new transfer draws 0 to 3 wait states
                if (!busy) begin
                    s        = lfsr_next(lfsr);
                    delay[1] = s[0];
                    s        = lfsr_next(s);
                    delay[0] = s[0];
                    lfsr     <= s;
                end
                if (delay == 2'd0) begin
                    wb_ack <= 1'b1;
                    busy   <= 1'b0;
                    if (wb_we) begin
                        mem[wb_adr[2 +: AW]] <= wb_dat_w;
                    end else begin
                        wb_dat_r <= mem[wb_adr[2 +: AW]];
                    end
                end else begin
                    busy      <= 1'b1;
                    wait_left <= delay - 2'd1;
                end
            end
        end
    end

endmodule
